//--- common/dmr_ckpt_pkg.sv
// Checkpoint-side types

`include "dmr_params.svh"

package dmr_ckpt_pkg;

  // One memory entry per group
  localparam int unsigned CkptAddrW = (`DMR_NUM_GRPS > 1) ? $clog2(`DMR_NUM_GRPS) : 1;

  // Checkpoint data word, same width as a core result
  typedef logic [`DMR_DATA_W-1:0] ckpt_word_t;

  // Memory index, equal to the group number
  typedef logic [CkptAddrW-1:0] ckpt_addr_t;

endpackage

//--- common/dmr_mode_pkg.sv
// Lockstep control-side types

package dmr_mode_pkg;

  // Redundancy mode of one core group
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Register map, status registers start at CfgStatBase
  typedef enum logic [2:0] {
    CTRL0 = 3'd0,
    CTRL1 = 3'd1,
    STAT0 = 3'd4,
    STAT1 = 3'd5
  } cfg_addr_e;

  localparam int unsigned CfgStatBase = 4;

  typedef logic [15:0] cfg_word_t;

  // CTRL bit positions
  localparam int unsigned CtrlEnBit    = 0;
  localparam int unsigned CtrlRapidBit = 1;
  localparam int unsigned CtrlForceBit = 2;

  // STAT field positions
  localparam int unsigned StatCntLsb = 8;

endpackage

//--- common/dmr_params.svh
// DMR lockstep build constants

`ifndef DMR_PARAMS_SVH
`define DMR_PARAMS_SVH

// Number of core groups, each pairing core A and core B
`define DMR_NUM_GRPS 2

// Width of a core result and of a checkpoint word
`define DMR_DATA_W 32

// Watchdog budget in clock cycles
`define DMR_TIMEOUT_CYC 20000

`endif

//--- dmr_ctrl/dmr_grp_ctrl.sv
// Per-group lockstep mode control

`timescale 1ns/10ps

module dmr_grp_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      enable_i,
  input  logic                      rapid_i,
  input  logic                      force_i,
  input  logic                      fetch_en_i,
  input  logic                      cores_synch_i,
  input  logic                      out_valid_i,
  input  dmr_ckpt_pkg::ckpt_word_t  out_a_i,
  input  dmr_ckpt_pkg::ckpt_word_t  out_b_i,
  input  logic                      recovery_done_i,
  output dmr_mode_pkg::dmr_mode_e   mode_o,
  output logic                      force_ack_o,
  output logic                      mismatch_incr_o,
  output logic                      ckpt_we_o,
  output dmr_ckpt_pkg::ckpt_word_t  ckpt_data_o,
  output logic                      recovery_req_o,
  output logic                      setback_o,
  output logic                      sw_synch_req_o,
  output logic                      sw_resynch_req_o,
  output logic                      grp_independent_o
);
  import dmr_mode_pkg::*;

  dmr_mode_e mode_d, mode_q;
  logic      cores_synch_q;
  logic      lanes_match;
  logic      synch_req, synch_sent_q, synch_pulse_q;
  logic      resynch_req, resynch_sent_q, resynch_pulse_q;
  logic      setback_d, setback_q;

  // Lane compare, only meaningful while running checked
  assign lanes_match     = out_a_i == out_b_i;
  assign ckpt_we_o       = mode_q == DMR_RUN && out_valid_i && lanes_match;
  assign ckpt_data_o     = out_a_i;
  assign mismatch_incr_o = mode_q == DMR_RUN && out_valid_i && !lanes_match;

  always_comb begin
    mode_d      = mode_q;
    force_ack_o = 1'b0;
    synch_req   = 1'b0;
    resynch_req = 1'b0;
    setback_d   = 1'b0;
    case (mode_q)
      DMR_RUN: begin
        if (force_i && rapid_i) begin
          force_ack_o = 1'b1;
          mode_d      = DMR_RESTORE;
        end
        if (mismatch_incr_o) begin
          if (rapid_i) begin
            mode_d = DMR_RESTORE;
          end else begin
            resynch_req = 1'b1;
          end
        end
        // Splitting the pair is allowed at any time
        if (!enable_i) begin
          mode_d = NON_DMR;
        end
      end
      DMR_RESTORE: begin
        if (recovery_done_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        // Ask software to align the cores, then wait for their answer
        if (enable_i && fetch_en_i) begin
          synch_req = 1'b1;
          if (cores_synch_q) begin
            mode_d    = DMR_RUN;
            setback_d = 1'b1;
          end
        end
      end
    endcase
    // Before the cores fetch, mode follows enable
    if (!fetch_en_i && mode_q != DMR_RESTORE) begin
      mode_d = enable_i ? DMR_RUN : NON_DMR;
    end
  end

  // Restore sequence starts on entry into DMR_RESTORE
  assign recovery_req_o = mode_d == DMR_RESTORE && mode_q != DMR_RESTORE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q          <= NON_DMR;
      cores_synch_q   <= 1'b0;
      synch_sent_q    <= 1'b0;
      synch_pulse_q   <= 1'b0;
      resynch_sent_q  <= 1'b0;
      resynch_pulse_q <= 1'b0;
      setback_q       <= 1'b0;
    end else begin
      mode_q          <= mode_d;
      cores_synch_q   <= cores_synch_i;
      synch_sent_q    <= synch_req;
      synch_pulse_q   <= synch_req && !synch_sent_q;
      resynch_sent_q  <= resynch_req;
      resynch_pulse_q <= resynch_req && !resynch_sent_q;
      setback_q       <= setback_d;
    end
  end

  assign mode_o            = mode_q;
  assign grp_independent_o = mode_q == NON_DMR;
  assign sw_synch_req_o    = synch_pulse_q;
  assign sw_resynch_req_o  = resynch_pulse_q;
  assign setback_o         = setback_q;

endmodule

//--- dmr_ctrl/dmr_recovery_unit.sv
// Checkpoint writer and restore sequencer

`timescale 1ns/10ps

module dmr_recovery_unit #(
  parameter int unsigned GrpIdx = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ckpt_we_i,
  input  dmr_ckpt_pkg::ckpt_word_t  ckpt_data_i,
  input  logic                      recovery_req_i,
  input  logic                      mem_gnt_i,
  input  dmr_ckpt_pkg::ckpt_word_t  mem_rdata_i,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output dmr_ckpt_pkg::ckpt_addr_t  mem_addr_o,
  output dmr_ckpt_pkg::ckpt_word_t  mem_wdata_o,
  output logic                      recovery_done_o,
  output logic                      restore_valid_o,
  output dmr_ckpt_pkg::ckpt_word_t  restore_data_o
);
  import dmr_ckpt_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_DATA} rd_state_e;

  rd_state_e  rd_state_d, rd_state_q;
  logic       wr_pend_q;
  ckpt_word_t wr_data_q;

  // A pending write goes first so the restore sees the newest checkpoint
  assign mem_req_o   = wr_pend_q || rd_state_q == RD_WAIT;
  assign mem_we_o    = wr_pend_q;
  assign mem_addr_o  = ckpt_addr_t'(GrpIdx);
  assign mem_wdata_o = wr_data_q;

  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: begin
        if (recovery_req_i) begin
          rd_state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (mem_gnt_i && !wr_pend_q) begin
          rd_state_d = RD_DATA;
        end
      end
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= RD_IDLE;
      wr_pend_q  <= 1'b0;
    end else begin
      rd_state_q <= rd_state_d;
      if (ckpt_we_i) begin
        wr_pend_q <= 1'b1;
      end else if (mem_gnt_i && wr_pend_q) begin
        wr_pend_q <= 1'b0;
      end
    end
  end

  // Latest matching result overwrites a write still waiting for grant
  always_ff @(posedge clk_i) begin
    if (ckpt_we_i) begin
      wr_data_q <= ckpt_data_i;
    end
  end

  assign restore_valid_o = rd_state_q == RD_DATA;
  assign recovery_done_o = rd_state_q == RD_DATA;
  assign restore_data_o  = mem_rdata_i;

endmodule

//--- dmr_lockstep.f
+incdir+common
common/dmr_mode_pkg.sv
common/dmr_ckpt_pkg.sv
verilog/dmr_cfg_regs.sv
dmr_ctrl/dmr_grp_ctrl.sv
dmr_ctrl/dmr_recovery_unit.sv
verilog/dmr_ckpt_arbiter.sv
verilog/dmr_ckpt_mem.sv
verilog/dmr_lockstep_top.sv
dv/dmr_clk_gen.sv
dv/dmr_lockstep_properties.sv
dv/dmr_lockstep_tb.sv

//--- dv/dmr_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps

module dmr_clk_gen #(
  parameter int unsigned HalfPeriod = 2,
  parameter int unsigned RstCycles  = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Reset held low for RstCycles rising edges
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- dv/dmr_lockstep_properties.sv
// Group control assertions

`timescale 1ns/10ps

module dmr_lockstep_properties (
  input logic                    clk_i,
  input logic                    rst_ni,
  input dmr_mode_pkg::dmr_mode_e mode_i,
  input logic                    recovery_done_i,
  input logic                    sw_synch_req_i,
  input logic                    sw_resynch_req_i
);
  import dmr_mode_pkg::*;

  // Software requests are single-cycle strobes
  synch_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_synch_req_i |=> !sw_synch_req_i)
    else $error("sw_synch_req stayed high for more than one cycle");

  resynch_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_resynch_req_i |=> !sw_resynch_req_i)
    else $error("sw_resynch_req stayed high for more than one cycle");

  // Restore is held until the recovery unit reports done
  restore_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode_i == DMR_RESTORE && !recovery_done_i |=> mode_i == DMR_RESTORE)
    else $error("DMR_RESTORE left before recovery_done");

endmodule

bind dmr_grp_ctrl dmr_lockstep_properties i_props (
  .clk_i,
  .rst_ni,
  .mode_i           (mode_o),
  .recovery_done_i,
  .sw_synch_req_i   (sw_synch_req_o),
  .sw_resynch_req_i (sw_resynch_req_o)
);

//--- dv/dmr_lockstep_tb.sv
// DMR lockstep testbench

`timescale 1ns/10ps
`include "dmr_params.svh"

module dmr_lockstep_tb;
  import dmr_mode_pkg::*;
  import dmr_ckpt_pkg::*;

  localparam int NG       = `DMR_NUM_GRPS;
  localparam int WaitCyc  = 64;
  localparam int DriveDly = 1;

  typedef enum logic [1:0] {EV_NONE, EV_RESTORE, EV_RESYNCH} event_e;

  // Predicted state of one group
  typedef struct packed {
    logic       rapid;
    dmr_mode_e  mode;
    ckpt_word_t ckpt;
    logic [7:0] cnt;
    event_e     ev;
  } grp_model_t;

  // Pulse still owed by the DUT
  typedef struct packed {
    ckpt_addr_t grp;
    event_e     ev;
    ckpt_word_t data;
  } exp_t;

  logic                clk;
  logic                rst_n;
  logic                cfg_we;
  cfg_addr_e           cfg_addr;
  cfg_word_t           cfg_wdata;
  cfg_word_t           cfg_rdata;
  logic [NG-1:0]       out_valid;
  logic [NG-1:0]       fetch_en;
  logic [NG-1:0]       cores_synch;
  ckpt_word_t [NG-1:0] out_a;
  ckpt_word_t [NG-1:0] out_b;
  ckpt_word_t [NG-1:0] restore_data;
  logic [NG-1:0]       setback;
  logic [NG-1:0]       sw_synch_req;
  logic [NG-1:0]       sw_resynch_req;
  logic [NG-1:0]       grp_independent;
  logic [NG-1:0]       restore_valid;

  grp_model_t mdl [NG];
  exp_t       exp_q [$];
  int         synch_cnt [NG];
  int         setback_cnt [NG];
  int         errors;
  int         tests_run;
  int         tests_failed;
  int         test_err_start;

  dmr_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dmr_lockstep_top DUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .cfg_we_i          (cfg_we),
    .cfg_addr_i        (cfg_addr),
    .cfg_wdata_i       (cfg_wdata),
    .cfg_rdata_o       (cfg_rdata),
    .out_valid_i       (out_valid),
    .out_a_i           (out_a),
    .out_b_i           (out_b),
    .fetch_en_i        (fetch_en),
    .cores_synch_i     (cores_synch),
    .setback_o         (setback),
    .sw_synch_req_o    (sw_synch_req),
    .sw_resynch_req_o  (sw_resynch_req),
    .grp_independent_o (grp_independent),
    .restore_valid_o   (restore_valid),
    .restore_data_o    (restore_data)
  );

  // Effect of one result strobe on a group
  function automatic grp_model_t dmr_model(input grp_model_t cur, input ckpt_word_t a,
                                           input ckpt_word_t b);
    grp_model_t nxt;
    nxt    = cur;
    nxt.ev = EV_NONE;
    if (cur.mode == DMR_RUN) begin
      if (a == b) begin
        nxt.ckpt = a;
      end else begin
        if (cur.cnt != 8'hff) begin
          nxt.cnt = cur.cnt + 8'd1;
        end
        if (cur.rapid) begin
          nxt.mode = DMR_RESTORE;
          nxt.ev   = EV_RESTORE;
        end else begin
          nxt.ev = EV_RESYNCH;
        end
      end
    end
    return nxt;
  endfunction

  function automatic cfg_addr_e ctrl_addr(input int g);
    return cfg_addr_e'(g[2:0]);
  endfunction

  function automatic cfg_addr_e stat_addr(input int g);
    return cfg_addr_e'(3'(CfgStatBase + g));
  endfunction

  function automatic int pending(input int g);
    int n;
    n = 0;
    foreach (exp_q[i]) begin
      if (exp_q[i].grp == ckpt_addr_t'(g)) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_word(input string what, input ckpt_word_t got, input ckpt_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_mode(input string what, input dmr_mode_e got, input dmr_mode_e exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_cfg(input string what, input cfg_word_t got, input cfg_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Match a DUT pulse against the oldest expectation of its group
  task automatic take_event(input int g, input event_e ev, input ckpt_word_t data);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i].grp == ckpt_addr_t'(g)) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Group %0d gave an unexpected %s pulse at %0t", g, ev.name(), $time);
      errors++;
    end else begin
      if (exp_q[idx].ev != ev) begin
        $display("Group %0d gave %s at %0t while %s was due", g, ev.name(), $time,
                 exp_q[idx].ev.name());
        errors++;
      end else if (ev == EV_RESTORE) begin
        check_word($sformatf("group %0d restore data", g), data, exp_q[idx].data);
        mdl[g].mode = DMR_RUN;
      end
      exp_q.delete(idx);
    end
  endtask

  // Compare process sampling outputs at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int g = 0; g < NG; g++) begin
        if (sw_synch_req[g]) begin
          synch_cnt[g]++;
        end
        if (setback[g]) begin
          setback_cnt[g]++;
        end
        if (restore_valid[g]) begin
          take_event(g, EV_RESTORE, restore_data[g]);
        end
        if (sw_resynch_req[g]) begin
          take_event(g, EV_RESYNCH, '0);
        end
      end
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #DriveDly;
    end
  endtask

  task automatic cfg_write(input cfg_addr_e addr, input cfg_word_t data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    idle(1);
    cfg_we = 1'b0;
  endtask

  task automatic cfg_read(input cfg_addr_e addr, output cfg_word_t data);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
    idle(1);
  endtask

  task automatic expect_event(input int g, input event_e ev);
    exp_t e;
    e.grp  = ckpt_addr_t'(g);
    e.ev   = ev;
    e.data = mdl[g].ckpt;
    exp_q.push_back(e);
  endtask

  task automatic drive_results(input logic [NG-1:0] valid, input ckpt_word_t [NG-1:0] a,
                               input ckpt_word_t [NG-1:0] b);
    for (int g = 0; g < NG; g++) begin
      if (valid[g]) begin
        mdl[g] = dmr_model(mdl[g], a[g], b[g]);
        if (mdl[g].ev != EV_NONE) begin
          expect_event(g, mdl[g].ev);
        end
      end
    end
    out_valid = valid;
    out_a     = a;
    out_b     = b;
    idle(1);
    out_valid = '0;
  endtask

  task automatic send_one(input int g, input ckpt_word_t a, input ckpt_word_t b);
    logic [NG-1:0]       v;
    ckpt_word_t [NG-1:0] av;
    ckpt_word_t [NG-1:0] bv;
    v     = '0;
    av    = '0;
    bv    = '0;
    v[g]  = 1'b1;
    av[g] = a;
    bv[g] = b;
    drive_results(v, av, bv);
  endtask

  task automatic wait_drained(input int g);
    int n;
    n = 0;
    while (pending(g) != 0 && n < WaitCyc) begin
      idle(1);
      n++;
    end
    if (pending(g) != 0) begin
      $display("Group %0d timed out after %0d cycles waiting for a pulse", g, WaitCyc);
      errors++;
    end
  endtask

  task automatic wait_count(input int g, input bit sb, input int start, input string what);
    int n;
    n = 0;
    while ((sb ? setback_cnt[g] : synch_cnt[g]) == start && n < WaitCyc) begin
      idle(1);
      n++;
    end
    if ((sb ? setback_cnt[g] : synch_cnt[g]) == start) begin
      $display("Group %0d gave no %s pulse within %0d cycles", g, what, WaitCyc);
      errors++;
    end
  endtask

  task automatic check_stat(input int g);
    cfg_word_t rd;
    cfg_read(stat_addr(g), rd);
    check_mode($sformatf("group %0d mode", g), dmr_mode_e'(rd[1:0]), mdl[g].mode);
    check_cfg($sformatf("STAT%0d", g), rd, {mdl[g].cnt, 6'd0, mdl[g].mode});
  endtask

  // Entry handshake with fetch_en already high
  task automatic enter_lockstep(input int g, input logic rapid);
    int start_s;
    int start_b;
    start_s = synch_cnt[g];
    start_b = setback_cnt[g];
    cfg_write(ctrl_addr(g), {13'd0, 1'b0, rapid, 1'b1});
    wait_count(g, 1'b0, start_s, "sw_synch_req");
    cores_synch[g] = 1'b1;
    idle(1);
    cores_synch[g] = 1'b0;
    wait_count(g, 1'b1, start_b, "setback");
    idle(2);
    if (synch_cnt[g] != start_s + 1) begin
      $display("Group %0d gave %0d sw_synch_req pulses instead of one", g,
               synch_cnt[g] - start_s);
      errors++;
    end
    mdl[g].mode  = DMR_RUN;
    mdl[g].rapid = rapid;
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_err_start);
    end
  endtask

  // Watchdog
  initial begin
    repeat (`DMR_TIMEOUT_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests completed", `DMR_TIMEOUT_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    ckpt_word_t          w;
    ckpt_word_t [NG-1:0] av;
    ckpt_word_t [NG-1:0] bv;
    cfg_word_t           rd;
    cfg_we       = 1'b0;
    cfg_addr     = CTRL0;
    cfg_wdata    = '0;
    out_valid    = '0;
    out_a        = '0;
    out_b        = '0;
    fetch_en     = '1;
    cores_synch  = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int g = 0; g < NG; g++) begin
      mdl[g]         = '0;
      synch_cnt[g]   = 0;
      setback_cnt[g] = 0;
    end
    void'($urandom(34));
    @(posedge rst_n);
    idle(1);

    start_test();
    cfg_write(CTRL0, 16'hfff6);
    cfg_write(CTRL1, 16'h0002);
    cfg_write(STAT0, 16'hffff);
    cfg_read(CTRL0, rd);
    check_cfg("CTRL0", rd, 16'h0006);
    cfg_read(CTRL1, rd);
    check_cfg("CTRL1", rd, 16'h0002);
    check_stat(0);
    check_stat(1);
    check_bit("group 0 independent", grp_independent[0], 1'b1);
    check_bit("group 1 independent", grp_independent[1], 1'b1);
    cfg_write(CTRL0, 16'h0000);
    cfg_write(CTRL1, 16'h0000);
    end_test("register access");

    start_test();
    enter_lockstep(0, 1'b0);
    check_stat(0);
    check_bit("group 0 independent", grp_independent[0], 1'b0);
    cfg_write(CTRL0, 16'h0000);
    mdl[0].mode = NON_DMR;
    idle(1);
    check_stat(0);
    check_bit("group 0 independent", grp_independent[0], 1'b1);
    end_test("lockstep entry and exit");

    start_test();
    enter_lockstep(0, 1'b1);
    repeat (8) begin
      w = $urandom;
      send_one(0, w, w);
    end
    w = $urandom;
    send_one(0, w, w ^ (32'd1 << $urandom_range(31, 0)));
    wait_drained(0);
    check_stat(0);
    end_test("rapid recovery restore");

    start_test();
    enter_lockstep(1, 1'b0);
    check_bit("group 1 independent", grp_independent[1], 1'b0);
    repeat (4) begin
      w = $urandom;
      send_one(1, w, w);
    end
    w = $urandom;
    send_one(1, w, ~w);
    wait_drained(1);
    idle(6);
    check_stat(1);
    end_test("software resynch");

    start_test();
    cfg_write(CTRL1, 16'h0003);
    mdl[1].rapid = 1'b1;
    av[0] = $urandom;
    av[1] = $urandom;
    drive_results('1, av, av);
    bv    = av;
    bv[0] = av[0] ^ 32'h0000_0001;
    bv[1] = av[1] ^ 32'h8000_0000;
    drive_results('1, av, bv);
    wait_drained(0);
    wait_drained(1);
    check_stat(0);
    check_stat(1);
    end_test("concurrent restores");

    start_test();
    repeat (2) begin
      w = $urandom;
      send_one(0, w, w);
    end
    expect_event(0, EV_RESTORE);
    mdl[0].mode = DMR_RESTORE;
    cfg_write(CTRL0, 16'h0007);
    wait_drained(0);
    cfg_read(CTRL0, rd);
    check_cfg("CTRL0 after force", rd, 16'h0003);
    check_stat(0);
    end_test("forced recovery");

    idle(4);
    if (exp_q.size() != 0) begin
      $display("%0d expected pulses never arrived", exp_q.size());
      errors++;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMR lockstep testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f dmr_lockstep.f \
  --top-module dmr_lockstep_tb \
  -o sim_dmr_lockstep
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_dmr_lockstep)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

//--- verilog/dmr_cfg_regs.sv
// Lockstep configuration registers

`timescale 1ns/10ps
`include "dmr_params.svh"

module dmr_cfg_regs (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        cfg_we_i,
  input  dmr_mode_pkg::cfg_addr_e                     cfg_addr_i,
  input  dmr_mode_pkg::cfg_word_t                     cfg_wdata_i,
  output dmr_mode_pkg::cfg_word_t                     cfg_rdata_o,
  input  dmr_mode_pkg::dmr_mode_e [`DMR_NUM_GRPS-1:0] grp_mode_i,
  input  logic [`DMR_NUM_GRPS-1:0]                    mismatch_incr_i,
  input  logic [`DMR_NUM_GRPS-1:0]                    force_ack_i,
  output logic [`DMR_NUM_GRPS-1:0]                    enable_o,
  output logic [`DMR_NUM_GRPS-1:0]                    rapid_o,
  output logic [`DMR_NUM_GRPS-1:0]                    force_o
);
  import dmr_mode_pkg::*;

  logic [`DMR_NUM_GRPS-1:0] enable_q;
  logic [`DMR_NUM_GRPS-1:0] rapid_q;
  logic [`DMR_NUM_GRPS-1:0] force_q;
  logic [7:0]               mm_cnt_q [`DMR_NUM_GRPS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= '0;
      rapid_q  <= '0;
      force_q  <= '0;
      for (int g = 0; g < `DMR_NUM_GRPS; g++) begin
        mm_cnt_q[g] <= '0;
      end
    end else begin
      for (int g = 0; g < `DMR_NUM_GRPS; g++) begin
        // Ack clears force, a write in the same cycle wins
        if (force_ack_i[g]) begin
          force_q[g] <= 1'b0;
        end
        if (cfg_we_i && cfg_addr_i == cfg_addr_e'(g)) begin
          enable_q[g] <= cfg_wdata_i[CtrlEnBit];
          rapid_q[g]  <= cfg_wdata_i[CtrlRapidBit];
          force_q[g]  <= cfg_wdata_i[CtrlForceBit];
        end
        // Counter saturates at 255
        if (mismatch_incr_i[g] && mm_cnt_q[g] != 8'hff) begin
          mm_cnt_q[g] <= mm_cnt_q[g] + 8'd1;
        end
      end
    end
  end

  // Status registers only decode, writes to them are dropped
  always_comb begin
    cfg_rdata_o = '0;
    for (int g = 0; g < `DMR_NUM_GRPS; g++) begin
      if (cfg_addr_i == cfg_addr_e'(g)) begin
        cfg_rdata_o[CtrlEnBit]    = enable_q[g];
        cfg_rdata_o[CtrlRapidBit] = rapid_q[g];
        cfg_rdata_o[CtrlForceBit] = force_q[g];
      end
      if (cfg_addr_i == cfg_addr_e'(CfgStatBase + g)) begin
        cfg_rdata_o[1:0]            = grp_mode_i[g];
        cfg_rdata_o[StatCntLsb +: 8] = mm_cnt_q[g];
      end
    end
  end

  assign enable_o = enable_q;
  assign rapid_o  = rapid_q;
  assign force_o  = force_q;

endmodule

//--- verilog/dmr_ckpt_arbiter.sv
// Round-robin checkpoint memory arbiter

`timescale 1ns/10ps

module dmr_ckpt_arbiter #(
  parameter type         payload_t = logic,
  parameter int unsigned NumReq    = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic     [NumReq-1:0] req_i,
  input  payload_t [NumReq-1:0] payload_i,
  output logic     [NumReq-1:0] gnt_o,
  output logic                  req_o,
  output payload_t              payload_o
);

  localparam int unsigned IdxW = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxW-1:0] last_q;
  logic [IdxW-1:0] sel;

  // Search starts one past the last winner
  always_comb begin
    int unsigned idx;
    gnt_o = '0;
    sel   = last_q;
    for (int unsigned i = 1; i <= NumReq; i++) begin
      idx = (last_q + i) % NumReq;
      if (req_i[idx] && gnt_o == '0) begin
        gnt_o[idx] = 1'b1;
        sel        = IdxW'(idx);
      end
    end
  end

  assign req_o     = |req_i;
  assign payload_o = payload_i[sel];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= IdxW'(NumReq - 1);
    end else if (req_o) begin
      last_q <= sel;
    end
  end

endmodule

//--- verilog/dmr_ckpt_mem.sv
// Checkpoint store, one word per group

`timescale 1ns/10ps
`include "dmr_params.svh"

module dmr_ckpt_mem (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      we_i,
  input  dmr_ckpt_pkg::ckpt_addr_t  addr_i,
  input  dmr_ckpt_pkg::ckpt_word_t  wdata_i,
  output dmr_ckpt_pkg::ckpt_word_t  rdata_o
);
  import dmr_ckpt_pkg::*;

  ckpt_word_t mem_q [`DMR_NUM_GRPS];
  ckpt_word_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int g = 0; g < `DMR_NUM_GRPS; g++) begin
        mem_q[g] <= '0;
      end
    end else if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read data appears the cycle after the grant
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- verilog/dmr_lockstep_top.sv
// DMR lockstep subsystem top

`timescale 1ns/10ps
`include "dmr_params.svh"

module dmr_lockstep_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         cfg_we_i,
  input  dmr_mode_pkg::cfg_addr_e                      cfg_addr_i,
  input  dmr_mode_pkg::cfg_word_t                      cfg_wdata_i,
  output dmr_mode_pkg::cfg_word_t                      cfg_rdata_o,
  input  logic [`DMR_NUM_GRPS-1:0]                     out_valid_i,
  input  dmr_ckpt_pkg::ckpt_word_t [`DMR_NUM_GRPS-1:0] out_a_i,
  input  dmr_ckpt_pkg::ckpt_word_t [`DMR_NUM_GRPS-1:0] out_b_i,
  input  logic [`DMR_NUM_GRPS-1:0]                     fetch_en_i,
  input  logic [`DMR_NUM_GRPS-1:0]                     cores_synch_i,
  output logic [`DMR_NUM_GRPS-1:0]                     setback_o,
  output logic [`DMR_NUM_GRPS-1:0]                     sw_synch_req_o,
  output logic [`DMR_NUM_GRPS-1:0]                     sw_resynch_req_o,
  output logic [`DMR_NUM_GRPS-1:0]                     grp_independent_o,
  output logic [`DMR_NUM_GRPS-1:0]                     restore_valid_o,
  output dmr_ckpt_pkg::ckpt_word_t [`DMR_NUM_GRPS-1:0] restore_data_o
);
  import dmr_mode_pkg::*;
  import dmr_ckpt_pkg::*;

  // Memory command carried through the arbiter
  typedef struct packed {
    logic       we;
    ckpt_addr_t addr;
    ckpt_word_t data;
  } mem_cmd_t;

  logic       [`DMR_NUM_GRPS-1:0] enable, rapid, force_en, force_ack, mismatch_incr;
  dmr_mode_e  [`DMR_NUM_GRPS-1:0] grp_mode;
  logic       [`DMR_NUM_GRPS-1:0] ckpt_we, recovery_req, recovery_done;
  ckpt_word_t [`DMR_NUM_GRPS-1:0] ckpt_data;
  logic       [`DMR_NUM_GRPS-1:0] mem_req, mem_gnt;
  mem_cmd_t   [`DMR_NUM_GRPS-1:0] mem_cmd;
  logic                           arb_req;
  mem_cmd_t                       arb_cmd;
  ckpt_word_t                     mem_rdata;

  dmr_cfg_regs i_cfg_regs (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_rdata_o,
    .grp_mode_i      (grp_mode),
    .mismatch_incr_i (mismatch_incr),
    .force_ack_i     (force_ack),
    .enable_o        (enable),
    .rapid_o         (rapid),
    .force_o         (force_en)
  );

  for (genvar g = 0; g < `DMR_NUM_GRPS; g++) begin : gen_grp
    dmr_grp_ctrl i_grp_ctrl (
      .clk_i,
      .rst_ni,
      .enable_i          (enable[g]),
      .rapid_i           (rapid[g]),
      .force_i           (force_en[g]),
      .fetch_en_i        (fetch_en_i[g]),
      .cores_synch_i     (cores_synch_i[g]),
      .out_valid_i       (out_valid_i[g]),
      .out_a_i           (out_a_i[g]),
      .out_b_i           (out_b_i[g]),
      .recovery_done_i   (recovery_done[g]),
      .mode_o            (grp_mode[g]),
      .force_ack_o       (force_ack[g]),
      .mismatch_incr_o   (mismatch_incr[g]),
      .ckpt_we_o         (ckpt_we[g]),
      .ckpt_data_o       (ckpt_data[g]),
      .recovery_req_o    (recovery_req[g]),
      .setback_o         (setback_o[g]),
      .sw_synch_req_o    (sw_synch_req_o[g]),
      .sw_resynch_req_o  (sw_resynch_req_o[g]),
      .grp_independent_o (grp_independent_o[g])
    );

    dmr_recovery_unit #(
      .GrpIdx (g)
    ) i_recovery_unit (
      .clk_i,
      .rst_ni,
      .ckpt_we_i       (ckpt_we[g]),
      .ckpt_data_i     (ckpt_data[g]),
      .recovery_req_i  (recovery_req[g]),
      .mem_gnt_i       (mem_gnt[g]),
      .mem_rdata_i     (mem_rdata),
      .mem_req_o       (mem_req[g]),
      .mem_we_o        (mem_cmd[g].we),
      .mem_addr_o      (mem_cmd[g].addr),
      .mem_wdata_o     (mem_cmd[g].data),
      .recovery_done_o (recovery_done[g]),
      .restore_valid_o (restore_valid_o[g]),
      .restore_data_o  (restore_data_o[g])
    );
  end

  dmr_ckpt_arbiter #(
    .payload_t (mem_cmd_t),
    .NumReq    (`DMR_NUM_GRPS)
  ) i_ckpt_arbiter (
    .clk_i,
    .rst_ni,
    .req_i     (mem_req),
    .payload_i (mem_cmd),
    .gnt_o     (mem_gnt),
    .req_o     (arb_req),
    .payload_o (arb_cmd)
  );

  dmr_ckpt_mem i_ckpt_mem (
    .clk_i,
    .rst_ni,
    .req_i   (arb_req),
    .we_i    (arb_cmd.we),
    .addr_i  (arb_cmd.addr),
    .wdata_i (arb_cmd.data),
    .rdata_o (mem_rdata)
  );

endmodule
